// ==== design/exu_pkg.sv ====
// Execute unit package
// Widths, word and index types, major opcodes, ALU operations
// and the load/store unit states shared by the RV32I execute stage

package exu_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////
    localparam int XLEN        = 32;
    localparam int RF_DEPTH    = 32;
    localparam int RFIDX_WIDTH = 5;

    typedef logic [XLEN-1:0]        xlen_t;
    typedef logic [RFIDX_WIDTH-1:0] rfidx_t;

    ////////////////////////////////////////////////////////////
    // Major opcodes kept by the decoder
    ////////////////////////////////////////////////////////////
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    ////////////////////////////////////////////////////////////
    // ALU operations
    ////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_B = 3'd5
    } alu_op_e;

    // LSU bus state, one access outstanding at most
    typedef enum logic {
        LSU_IDLE = 1'b0,
        LSU_BUS  = 1'b1
    } lsu_state_e;

endpackage

// ==== design/exu_decoder.sv ====
// Instruction decoder
// Splits register fields, builds the I, S or U immediate and maps
// LUI, ADDI, ADD, SUB, AND, OR, XOR, LW and SW to control signals.
// Anything else is flagged illegal with all side effects cleared

module exu_decoder (
    input  exu_pkg::xlen_t   instr,
    output exu_pkg::rfidx_t  rs1_idx,
    output exu_pkg::rfidx_t  rs2_idx,
    output exu_pkg::rfidx_t  rd_idx,
    output exu_pkg::xlen_t   imm,
    output exu_pkg::alu_op_e alu_op,
    output logic             use_imm,
    output logic             rd_wen,
    output logic             is_load,
    output logic             is_store,
    output logic             illegal
);
    import exu_pkg::*;

    opcode_e    opc;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opc     = opcode_e'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];
    assign rd_idx  = instr[11:7];

    ////////////////////////////////////////////////////////////
    // Immediate generation
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (opc)
            OPC_LUI:   imm = {instr[31:12], 12'b0};
            OPC_STORE: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            default:   imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////
    // rd_wen covers the ALU path only; loads write back later
    always_comb begin
        alu_op   = ALU_ADD;
        use_imm  = 1'b0;
        rd_wen   = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        illegal  = 1'b0;
        case (opc)
            OPC_LUI: begin
                alu_op  = ALU_PASS_B;
                use_imm = 1'b1;
                rd_wen  = 1'b1;
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                rd_wen  = 1'b1;
                illegal = (funct3 != 3'b000);
            end
            OPC_OP: begin
                rd_wen = 1'b1;
                if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    alu_op = ALU_SUB;
                end else if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  alu_op = ALU_ADD;
                        3'b100:  alu_op = ALU_XOR;
                        3'b110:  alu_op = ALU_OR;
                        3'b111:  alu_op = ALU_AND;
                        default: illegal = 1'b1;
                    endcase
                end else begin
                    illegal = 1'b1;
                end
            end
            OPC_LOAD: begin
                is_load = 1'b1;
                illegal = (funct3 != 3'b010);
            end
            OPC_STORE: begin
                is_store = 1'b1;
                illegal  = (funct3 != 3'b010);
            end
            default: illegal = 1'b1;
        endcase

        // Faulting instructions must not touch state
        if (illegal) begin
            rd_wen   = 1'b0;
            is_load  = 1'b0;
            is_store = 1'b0;
        end
    end

endmodule

// ==== design/exu_regfile.sv ====
// Integer register file
// 32 words, two combinational read ports and one write port at the
// clock edge; x0 ignores writes and always reads zero

module exu_regfile (
    input  logic            clk,
    input  exu_pkg::rfidx_t rs1_idx,
    input  exu_pkg::rfidx_t rs2_idx,
    input  exu_pkg::rfidx_t wr_idx,
    input  logic            wr_en,
    input  exu_pkg::xlen_t  wr_data,
    output exu_pkg::xlen_t  rs1_data,
    output exu_pkg::xlen_t  rs2_data
);
    import exu_pkg::*;

    // Storage, contents undefined until written
    xlen_t regs [RF_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

// ==== design/exu_alu.sv ====
// Integer ALU
// Picks the second operand from the immediate or rs2, then applies
// add, sub, and, or, xor or a pass of operand b for LUI

module exu_alu (
    input  exu_pkg::xlen_t   rs1_data,
    input  exu_pkg::xlen_t   rs2_data,
    input  exu_pkg::xlen_t   imm,
    input  logic             use_imm,
    input  exu_pkg::alu_op_e alu_op,
    output exu_pkg::xlen_t   result
);
    import exu_pkg::*;

    xlen_t op_a;
    xlen_t op_b;

    ////////////////////////////////////////////////////////////
    // Operand select
    ////////////////////////////////////////////////////////////
    assign op_a = rs1_data;
    assign op_b = use_imm ? imm : rs2_data;

    ////////////////////////////////////////////////////////////
    // Operations
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_OR:     result = op_a | op_b;
            ALU_XOR:    result = op_a ^ op_b;
            // LUI, immediate already shifted by the decoder
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

endmodule

// ==== design/exu_lsu.sv ====
// Load/store unit
// Forms rs1 plus immediate, rejects unaligned words and runs one
// Wishbone classic cycle per aligned LW or SW. Holds the stage busy
// until the slave acknowledges

module exu_lsu (
    input  logic            clk,
    input  logic            rst,
    input  logic            instr_valid,
    input  logic            is_load,
    input  logic            is_store,
    input  exu_pkg::xlen_t  rs1_data,
    input  exu_pkg::xlen_t  rs2_data,
    input  exu_pkg::xlen_t  imm,
    input  exu_pkg::rfidx_t rd_idx,
    input  exu_pkg::xlen_t  wb_dat_r,
    input  logic            wb_ack,
    output logic            exu_ready,
    output logic            accept,
    output logic            misalign,
    output logic            ld_done,
    output exu_pkg::xlen_t  ld_data,
    output exu_pkg::rfidx_t ld_rd,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output exu_pkg::xlen_t  wb_adr,
    output exu_pkg::xlen_t  wb_dat_w
);
    import exu_pkg::*;

    lsu_state_e state;
    xlen_t      eff_addr;
    logic       is_mem;
    logic       start;

    // Access registers, held for the whole bus cycle
    xlen_t      adr_q;
    xlen_t      dat_q;
    logic       we_q;
    rfidx_t     rd_q;

    ////////////////////////////////////////////////////////////
    // Acceptance and address check
    ////////////////////////////////////////////////////////////
    assign exu_ready = (state == LSU_IDLE);
    assign accept    = instr_valid & exu_ready;
    assign is_mem    = is_load | is_store;
    assign eff_addr  = rs1_data + imm;
    assign misalign  = accept & is_mem & (eff_addr[1:0] != 2'b00);
    assign start     = accept & is_mem & ~misalign;

    ////////////////////////////////////////////////////////////
    // Bus state
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LSU_IDLE;
        end else if (start) begin
            state <= LSU_BUS;
        end else if (state == LSU_BUS && wb_ack) begin
            state <= LSU_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= eff_addr;
            dat_q <= rs2_data;
            we_q  <= is_store;
            rd_q  <= rd_idx;
        end
    end

    // Wishbone master outputs
    assign wb_cyc   = (state == LSU_BUS);
    assign wb_stb   = (state == LSU_BUS);
    assign wb_we    = (state == LSU_BUS) & we_q;
    assign wb_adr   = adr_q;
    assign wb_dat_w = dat_q;

    // Load completion, written back on the ack edge
    assign ld_done = (state == LSU_BUS) & wb_ack & ~we_q;
    assign ld_data = wb_dat_r;
    assign ld_rd   = rd_q;

endmodule

// ==== design/exu_wbck.sv ====
// Write-back unit
// Steers either a finished load or an accepted ALU result onto the
// register write port and registers a one-cycle exception pulse

module exu_wbck (
    input  logic            clk,
    input  logic            rst,
    input  logic            accept,
    input  logic            rd_wen,
    input  logic            illegal,
    input  logic            misalign,
    input  exu_pkg::rfidx_t rd_idx,
    input  exu_pkg::xlen_t  alu_result,
    input  logic            ld_done,
    input  exu_pkg::xlen_t  ld_data,
    input  exu_pkg::rfidx_t ld_rd,
    output logic            rf_wen,
    output exu_pkg::rfidx_t rf_idx,
    output exu_pkg::xlen_t  rf_data,
    output logic            exu_excp
);
    import exu_pkg::*;

    ////////////////////////////////////////////////////////////
    // Register write port
    ////////////////////////////////////////////////////////////
    // Load completes only while busy, so it never meets an accept
    always_comb begin
        rf_wen  = 1'b0;
        rf_idx  = rfidx_t'(0);
        rf_data = xlen_t'(0);
        if (ld_done) begin
            rf_wen  = 1'b1;
            rf_idx  = ld_rd;
            rf_data = ld_data;
        end else if (accept && rd_wen) begin
            rf_wen  = 1'b1;
            rf_idx  = rd_idx;
            rf_data = alu_result;
        end
    end

    // Exception pulse, cycle after the faulting accept
    always_ff @(posedge clk) begin
        if (rst) begin
            exu_excp <= 1'b0;
        end else begin
            exu_excp <= accept & (illegal | misalign);
        end
    end

endmodule

// ==== design/exu_top.sv ====
// Execute unit top level
// Decoder, register file, ALU and LSU side by side, with the
// write-back unit merging their results into the register file

module exu_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           instr_valid,
    input  exu_pkg::xlen_t instr,
    output logic           exu_ready,
    output logic           exu_excp,
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           wb_we,
    output exu_pkg::xlen_t wb_adr,
    output exu_pkg::xlen_t wb_dat_w,
    input  exu_pkg::xlen_t wb_dat_r,
    input  logic           wb_ack
);
    import exu_pkg::*;

    ////////////////////////////////////////////////////////////
    // Decode and operand read
    ////////////////////////////////////////////////////////////
    rfidx_t  rs1_idx;
    rfidx_t  rs2_idx;
    rfidx_t  rd_idx;
    xlen_t   imm;
    alu_op_e alu_op;
    logic    use_imm;
    logic    rd_wen;
    logic    is_load;
    logic    is_store;
    logic    illegal;
    xlen_t   rs1_data;
    xlen_t   rs2_data;

    // Write port from write-back
    logic    rf_wen;
    rfidx_t  rf_idx;
    xlen_t   rf_data;

    exu_decoder u_decoder (
        .instr    (instr),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rd_idx   (rd_idx),
        .imm      (imm),
        .alu_op   (alu_op),
        .use_imm  (use_imm),
        .rd_wen   (rd_wen),
        .is_load  (is_load),
        .is_store (is_store),
        .illegal  (illegal)
    );

    exu_regfile u_regfile (
        .clk      (clk),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .wr_idx   (rf_idx),
        .wr_en    (rf_wen),
        .wr_data  (rf_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    ////////////////////////////////////////////////////////////
    // ALU and LSU
    ////////////////////////////////////////////////////////////
    xlen_t   alu_result;
    logic    accept;
    logic    misalign;
    logic    ld_done;
    xlen_t   ld_data;
    rfidx_t  ld_rd;

    exu_alu u_alu (
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .use_imm  (use_imm),
        .alu_op   (alu_op),
        .result   (alu_result)
    );

    exu_lsu u_lsu (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .is_load     (is_load),
        .is_store    (is_store),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .rd_idx      (rd_idx),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .exu_ready   (exu_ready),
        .accept      (accept),
        .misalign    (misalign),
        .ld_done     (ld_done),
        .ld_data     (ld_data),
        .ld_rd       (ld_rd),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w)
    );

    // Write-back
    exu_wbck u_wbck (
        .clk        (clk),
        .rst        (rst),
        .accept     (accept),
        .rd_wen     (rd_wen),
        .illegal    (illegal),
        .misalign   (misalign),
        .rd_idx     (rd_idx),
        .alu_result (alu_result),
        .ld_done    (ld_done),
        .ld_data    (ld_data),
        .ld_rd      (ld_rd),
        .rf_wen     (rf_wen),
        .rf_idx     (rf_idx),
        .rf_data    (rf_data),
        .exu_excp   (exu_excp)
    );

endmodule

// ==== dv/exu_chk.sv ====
// Execute unit protocol checker
// Concurrent assertions on the Wishbone handshake, the instruction
// ready signal and the exception pulse, bound into exu_top

module exu_chk (
    input logic           clk,
    input logic           rst,
    input logic           exu_ready,
    input logic           exu_excp,
    input logic           wb_cyc,
    input logic           wb_stb,
    input logic           wb_we,
    input exu_pkg::xlen_t wb_adr,
    input exu_pkg::xlen_t wb_dat_w,
    input logic           wb_ack
);

    ////////////////////////////////////////////////////////////
    // Wishbone classic handshake
    ////////////////////////////////////////////////////////////
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else $error("wb_stb high outside a bus cycle");

    // Request held until the slave answers
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=>
        (wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w)))
        else $error("Wishbone request changed before wb_ack");

    ////////////////////////////////////////////////////////////
    // Stage control
    ////////////////////////////////////////////////////////////
    a_busy_on_bus: assert property (@(posedge clk) disable iff (rst) wb_cyc |-> !exu_ready)
        else $error("exu_ready high during a bus cycle");

    a_excp_pulse: assert property (@(posedge clk) disable iff (rst) exu_excp |=> !exu_excp)
        else $error("exu_excp high for two cycles in a row");

    // Idle bus and no exception straight out of reset
    a_reset_idle: assert property (@(posedge clk) rst |=> (!wb_cyc && !exu_excp && exu_ready))
        else $error("reset did not leave the stage idle");

endmodule

bind exu_top exu_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .exu_ready (exu_ready),
    .exu_excp  (exu_excp),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_ack    (wb_ack)
);

// ==== dv/exu_tb.sv ====
// Execute unit testbench
// Runs a short RV32I program through the DUT, answers its Wishbone
// cycles from a small memory with random ack delays and checks every
// stored word against a reference register model

module exu_tb;
    import exu_pkg::*;

    localparam int     MEM_WORDS      = 64;
    localparam int     TIMEOUT_CYCLES = 1000;
    localparam integer SEED           = 32'h17b1;

    logic  clk = 1'b0;
    logic  rst;
    logic  instr_valid;
    xlen_t instr;
    logic  exu_ready;
    logic  exu_excp;
    logic  wb_cyc;
    logic  wb_stb;
    logic  wb_we;
    xlen_t wb_adr;
    xlen_t wb_dat_w;
    xlen_t wb_dat_r = '0;
    logic  wb_ack   = 1'b0;

    integer     seed;
    int         cycle_cnt = 0;
    int         store_cnt = 0;
    int         acc_cnt   = 0;
    string      test_name;
    xlen_t      ref_regs [RF_DEPTH];
    xlen_t      mem [MEM_WORDS];
    xlen_t      init_words [MEM_WORDS];
    logic [1:0] ack_wait [MEM_WORDS];

    // Expected stores in bus order
    xlen_t      exp_adr [$];
    xlen_t      exp_dat [$];
    string      exp_name [$];

    exu_top u_dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("Timeout: program not finished after %0d cycles",
                                    TIMEOUT_CYCLES));
        end
    end

    ////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input xlen_t exp_v, input xlen_t act_v);
        assert (act_v === exp_v) else
            stop_on_error($sformatf("ERROR %s: expected %08h, actual %08h",
                                    name, exp_v, act_v));
    endtask

    ////////////////////////////////////////////////////////////
    // Instruction assembly and issue
    ////////////////////////////////////////////////////////////
    function automatic xlen_t sext12(input logic [11:0] imm12);
        return {{20{imm12[11]}}, imm12};
    endfunction

    function automatic xlen_t enc_i(input logic [6:0] opc, input logic [11:0] imm12,
                                    input rfidx_t rs1, input logic [2:0] f3, input rfidx_t rd);
        return {imm12, rs1, f3, rd, opc};
    endfunction

    // Returns on the falling edge after the accepting edge
    task automatic issue(input xlen_t ins, input logic fault, input logic bus);
        while (!exu_ready) @(negedge clk);
        instr_valid = 1'b1;
        instr       = ins;
        @(negedge clk);
        instr_valid = 1'b0;
        check_value({test_name, " exu_excp"}, xlen_t'(fault), xlen_t'(exu_excp));
        if (bus) begin
            assert (wb_cyc) else stop_on_error("No bus cycle started for an aligned access");
        end
        if (fault) begin
            assert (!wb_cyc) else stop_on_error("A bus cycle started for a faulting instruction");
            @(negedge clk);
            assert (!exu_excp) else stop_on_error("exu_excp stayed high for a second cycle");
        end
    endtask

    task automatic load_upper(input rfidx_t rd, input logic [19:0] imm20);
        issue({imm20, rd, OPC_LUI}, 1'b0, 1'b0);
        if (rd != 5'd0) begin
            ref_regs[rd] = {imm20, 12'b0};
        end
    endtask

    task automatic add_imm(input rfidx_t rd, input rfidx_t rs1, input logic [11:0] imm12);
        xlen_t sum;
        sum = ref_regs[rs1] + sext12(imm12);
        issue(enc_i(OPC_OP_IMM, imm12, rs1, 3'b000, rd), 1'b0, 1'b0);
        if (rd != 5'd0) begin
            ref_regs[rd] = sum;
        end
    endtask

    task automatic reg_op(input alu_op_e op, input rfidx_t rd, input rfidx_t rs1,
                          input rfidx_t rs2);
        logic [6:0] f7;
        logic [2:0] f3;
        xlen_t      res;
        case (op)
            ALU_SUB: res = ref_regs[rs1] - ref_regs[rs2];
            ALU_AND: res = ref_regs[rs1] & ref_regs[rs2];
            ALU_OR:  res = ref_regs[rs1] | ref_regs[rs2];
            ALU_XOR: res = ref_regs[rs1] ^ ref_regs[rs2];
            default: res = ref_regs[rs1] + ref_regs[rs2];
        endcase
        case (op)
            ALU_AND: f3 = 3'b111;
            ALU_OR:  f3 = 3'b110;
            ALU_XOR: f3 = 3'b100;
            default: f3 = 3'b000;
        endcase
        f7 = (op == ALU_SUB) ? 7'b0100000 : 7'b0000000;
        issue({f7, rs2, rs1, f3, rd, OPC_OP}, 1'b0, 1'b0);
        if (rd != 5'd0) begin
            ref_regs[rd] = res;
        end
    endtask

    task automatic load_word(input rfidx_t rd, input rfidx_t rs1, input logic [11:0] imm12);
        xlen_t addr;
        logic  fault;
        addr  = ref_regs[rs1] + sext12(imm12);
        fault = (addr[1:0] != 2'b00);
        issue(enc_i(OPC_LOAD, imm12, rs1, 3'b010, rd), fault, !fault);
        if (!fault && rd != 5'd0) begin
            ref_regs[rd] = mem[addr[7:2]];
        end
    endtask

    task automatic store_word(input rfidx_t rs2, input rfidx_t rs1, input logic [11:0] imm12);
        xlen_t addr;
        logic  fault;
        addr  = ref_regs[rs1] + sext12(imm12);
        fault = (addr[1:0] != 2'b00);
        if (!fault) begin
            exp_adr.push_back(addr);
            exp_dat.push_back(ref_regs[rs2]);
            exp_name.push_back(test_name);
        end
        issue({imm12[11:5], rs2, rs1, 3'b010, imm12[4:0], OPC_STORE}, fault, !fault);
    endtask

    ////////////////////////////////////////////////////////////
    // Wishbone memory model
    ////////////////////////////////////////////////////////////
    // Ack after 0 to 3 wait cycles taken from the delay table
    always @(negedge clk) begin : slave_model
        int waits;
        wb_ack = 1'b0;
        if (rst) begin
            mem   = init_words;
            waits = -1;
        end else if (!wb_cyc) begin
            waits = -1;
        end else if (wb_stb) begin
            if (waits < 0) begin
                waits   = int'(ack_wait[acc_cnt % MEM_WORDS]);
                acc_cnt = acc_cnt + 1;
            end
            if (waits > 0) begin
                waits = waits - 1;
            end else begin
                wb_ack = 1'b1;
                if (!wb_we) begin
                    wb_dat_r = mem[wb_adr[7:2]];
                end else if (store_cnt >= exp_dat.size()) begin
                    stop_on_error("A store reached the bus that the program never issued");
                end else begin
                    check_value({exp_name[store_cnt], " addr"}, exp_adr[store_cnt], wb_adr);
                    check_value(exp_name[store_cnt], exp_dat[store_cnt], wb_dat_w);
                    mem[wb_adr[7:2]] = wb_dat_w;
                    store_cnt        = store_cnt + 1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Program
    ////////////////////////////////////////////////////////////
    initial begin
        int    i;
        xlen_t r;
        seed        = SEED;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        test_name   = "reset";
        ref_regs[0] = '0;
        for (i = 0; i < MEM_WORDS; i++) begin
            init_words[i] = $random(seed);
            r             = $random(seed);
            ack_wait[i]   = r[1:0];
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // Random operands in x1..x6 with results stored from word 33 up
        test_name = "alu";
        for (i = 1; i < 7; i++) begin
            r = $random(seed);
            load_upper(rfidx_t'(i), r[31:12]);
            add_imm(rfidx_t'(i), rfidx_t'(i), r[11:0]);
        end
        reg_op(ALU_ADD, 5'd7, 5'd1, 5'd2);
        reg_op(ALU_SUB, 5'd8, 5'd3, 5'd4);
        reg_op(ALU_AND, 5'd9, 5'd5, 5'd6);
        reg_op(ALU_OR, 5'd10, 5'd1, 5'd3);
        reg_op(ALU_XOR, 5'd11, 5'd2, 5'd4);
        for (i = 1; i < 12; i++) begin
            store_word(rfidx_t'(i), 5'd0, 12'(128 + 4 * i));
        end

        // Words 4..7 through base x20 copied out to words 48..51
        test_name = "load";
        add_imm(5'd20, 5'd0, 12'd16);
        for (i = 0; i < 4; i++) begin
            load_word(5'd21, 5'd20, 12'(4 * i));
            store_word(5'd21, 5'd0, 12'(192 + 4 * i));
        end

        // JAL and SLL are outside the kept set
        test_name = "illegal";
        issue({20'h00000, 5'd7, 7'b1101111}, 1'b1, 1'b0);
        store_word(5'd7, 5'd0, 12'd224);
        issue({7'b0000000, 5'd2, 5'd1, 3'b001, 5'd8, OPC_OP}, 1'b1, 1'b0);
        store_word(5'd8, 5'd0, 12'd228);

        test_name = "misalign";
        load_word(5'd9, 5'd20, 12'd2);
        store_word(5'd9, 5'd0, 12'd232);
        store_word(5'd1, 5'd20, 12'd1);

        test_name = "x0";
        add_imm(5'd0, 5'd3, 12'h123);
        store_word(5'd0, 5'd0, 12'd236);

        while (!exu_ready) @(negedge clk);
        @(negedge clk);
        if (store_cnt != exp_dat.size()) begin
            stop_on_error("Program ended with expected stores missing from the bus");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// ==== sim.f ====
design/exu_pkg.sv
design/exu_decoder.sv
design/exu_regfile.sv
design/exu_alu.sv
design/exu_lsu.sv
design/exu_wbck.sv
design/exu_top.sv
dv/exu_chk.sv
dv/exu_tb.sv

// ==== Makefile ====
# Verilator build for the execute unit testbench
VERILATOR ?= verilator
TOP       ?= exu_tb
FLAGS     ?= --timing --assert
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
